/* hw/axi_write_port.sv */
module axi_write_port (
	input  logic                 clk,
	input  logic                 rst,

	// write address
	input  uart_pkg::axi_addr_t  awaddr,
	input  logic                 awvalid,
	output logic                 awready,

	// write data
	input  uart_pkg::axi_data_t  wdata,
	input  uart_pkg::axi_strb_t  wstrb,
	input  logic                 wvalid,
	output logic                 wready,

	// write response
	output uart_pkg::axi_resp_t  bresp,
	output logic                 bvalid,
	input  logic                 bready,

	// pacing from ready_jitter
	input  logic                 trigger,

	// fifo side
	output logic                 push,
	output uart_pkg::uart_byte_t push_byte,
	input  logic                 full
);

	uart_pkg::write_state_t state;

	// captured write, only the parts the decode needs
	logic [11:0]          offset_q;
	uart_pkg::uart_byte_t byte_q;
	logic                 strb0_q;

	logic aw_xfer;
	logic write_ok;
	logic resp_go;

	// aw and w only accepted together
	assign aw_xfer = awvalid && awready && wvalid && wready;

	assign write_ok = (offset_q == uart_pkg::TXDATA_OFFSET) && strb0_q;

	// a valid write also needs room in the fifo, otherwise the response stalls
	assign resp_go = trigger && (!write_ok || !full);

	assign push      = (state == uart_pkg::WRITE_DATA) && resp_go && write_ok;
	assign push_byte = byte_q;

	always_ff @(posedge clk) begin
		if (state == uart_pkg::LISTEN_ADDR && aw_xfer) begin
			offset_q <= awaddr[11:0]; // upper address bits ignored
			byte_q   <= wdata[7:0];
			strb0_q  <= wstrb[0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state   <= uart_pkg::LISTEN_ADDR;
			awready <= 1'b1;
			wready  <= 1'b1;
			bvalid  <= 1'b0;
			bresp   <= uart_pkg::RESP_OKAY;
		end else begin
			case (state)
				uart_pkg::LISTEN_ADDR: begin
					if (trigger) begin
						awready <= 1'b1;
						wready  <= 1'b1;
					end
					// capture wins over a trigger in the same cycle
					if (aw_xfer) begin
						awready <= 1'b0;
						wready  <= 1'b0;
						state   <= uart_pkg::WRITE_DATA;
					end
				end
				uart_pkg::WRITE_DATA: begin
					if (resp_go) begin
						bvalid <= 1'b1;
						if (write_ok) begin
							bresp <= uart_pkg::RESP_OKAY;
						end else begin
							bresp <= uart_pkg::RESP_SLVERR; // bad offset or byte 0 not strobed
						end
						state <= uart_pkg::WAIT_RESP;
					end
				end
				uart_pkg::WAIT_RESP: begin
					if (bready) begin
						bvalid <= 1'b0; // readies come back on a later trigger
						state  <= uart_pkg::LISTEN_ADDR;
					end
				end
				default: begin
					state <= uart_pkg::LISTEN_ADDR;
				end
			endcase
		end
	end

endmodule

/* hw/ready_jitter.sv */
module ready_jitter #(
	parameter logic [15:0] JITTER_SEED = 16'hACE1
) (
	input  logic clk,
	input  logic rst,
	output logic trigger
);

	// x^16 + x^14 + x^13 + x^11 + 1, right-shifting galois form
	localparam logic [15:0] TAPS = 16'hB400;

	logic [15:0] lfsr;

	always_ff @(posedge clk) begin
		if (!rst) begin
			lfsr <= JITTER_SEED;
		end else if (lfsr[0]) begin
			lfsr <= {1'b0, lfsr[15:1]} ^ TAPS;
		end else begin
			lfsr <= {1'b0, lfsr[15:1]};
		end
	end

	// roughly one cycle in four, never stuck since lfsr is never zero
	assign trigger = &lfsr[1:0];

endmodule

/* hw/tx_fifo.sv */
module tx_fifo #(
	parameter int FIFO_DEPTH = 4 // power of two
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  uart_pkg::uart_byte_t push_byte,
	input  logic                pop,
	output uart_pkg::uart_byte_t head_byte,
	output logic                empty,
	output logic                full
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = PTR_W + 1;

	uart_pkg::uart_byte_t mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				count <= count + 1'b1;
			end else if (rd_en && !wr_en) begin
				count <= count - 1'b1;
			end
		end
	end

	assign head_byte = mem[rd_ptr]; // show-ahead
	assign empty     = (count == '0);
	assign full      = (count == CNT_W'(FIFO_DEPTH));

endmodule

/* hw/uart_axi_top.sv */
module uart_axi_top #(
	parameter int          CLKS_PER_BIT = 8,
	parameter int          FIFO_DEPTH   = 4,
	parameter logic [15:0] JITTER_SEED  = 16'hACE1
) (
	input  logic                clk,
	input  logic                rst,

	input  uart_pkg::axi_addr_t awaddr,
	input  logic                awvalid,
	output logic                awready,

	input  uart_pkg::axi_data_t wdata,
	input  uart_pkg::axi_strb_t wstrb,
	input  logic                wvalid,
	output logic                wready,

	output uart_pkg::axi_resp_t bresp,
	output logic                bvalid,
	input  logic                bready,

	output logic                txd
);

	logic                 trigger;
	logic                 push;
	uart_pkg::uart_byte_t push_byte;
	logic                 full;
	logic                 empty;
	logic                 pop;
	uart_pkg::uart_byte_t head_byte;

	axi_write_port u_write_port (
		.clk       (clk),
		.rst       (rst),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.trigger   (trigger),
		.push      (push),
		.push_byte (push_byte),
		.full      (full)
	);

	ready_jitter #(.JITTER_SEED(JITTER_SEED)) u_jitter (
		.clk     (clk),
		.rst     (rst),
		.trigger (trigger)
	);

	tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_byte (push_byte),
		.pop       (pop),
		.head_byte (head_byte),
		.empty     (empty),
		.full      (full)
	);

	uart_tx_serializer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_serializer (
		.clk       (clk),
		.rst       (rst),
		.empty     (empty),
		.head_byte (head_byte),
		.pop       (pop),
		.txd       (txd)
	);

endmodule

/* hw/uart_pkg.sv */
package uart_pkg;

	// AXI-lite write side
	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0]  axi_strb_t;
	typedef logic [1:0]  axi_resp_t;

	// one serial character
	typedef logic [7:0] uart_byte_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// transmit data register, matched on addr[11:0] only
	localparam logic [11:0] TXDATA_OFFSET = 12'h000;

	// write port FSM
	typedef enum logic [1:0] {
		LISTEN_ADDR = 2'd0, // readies up, waiting for joint aw/w
		WRITE_DATA  = 2'd1, // decode and push, paced by trigger
		WAIT_RESP   = 2'd2  // bvalid held until bready
	} write_state_t;

endpackage

/* hw/uart_tx_serializer.sv */
module uart_tx_serializer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 empty,
	input  uart_pkg::uart_byte_t head_byte,
	output logic                 pop,
	output logic                 txd
);

	localparam int BAUD_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [3:0] LAST_BIT = 4'd9; // stop bit index

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

	tx_state_t   state;
	logic [BAUD_W-1:0] baud_cnt;
	logic [3:0]  bit_idx;
	logic [9:0]  frame; // lsb is on the line
	logic        bit_end;
	logic        frame_end;

	assign bit_end   = (state == TX_SEND) && (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));
	assign frame_end = bit_end && (bit_idx == LAST_BIT);

	// next byte is taken when idle or right at the end of the stop bit
	assign pop = !empty && ((state == TX_IDLE) || frame_end);

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			frame    <= '1; // line idles high
		end else if (pop) begin
			// stop, data lsb first, start
			state    <= TX_SEND;
			baud_cnt <= '0;
			bit_idx  <= '0;
			frame    <= {1'b1, head_byte, 1'b0};
		end else if (frame_end) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			frame    <= '1;
		end else if (bit_end) begin
			baud_cnt <= '0;
			bit_idx  <= bit_idx + 1'b1;
			frame    <= {1'b1, frame[9:1]}; // shift ones in behind
		end else if (state == TX_SEND) begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	assign txd = frame[0];

endmodule

/* list.f */
hw/uart_pkg.sv
hw/ready_jitter.sv
hw/tx_fifo.sv
hw/uart_tx_serializer.sv
hw/axi_write_port.sv
hw/uart_axi_top.sv
testbench/uart_axi_checker.sv
testbench/uart_axi_tb.sv

/* testbench/uart_axi_checker.sv */
module uart_axi_checker #(
	parameter int CLKS_PER_BIT = 8
) (
	input logic                clk,
	input logic                rst,
	input logic                awvalid,
	input logic                awready,
	input logic                wvalid,
	input logic                wready,
	input uart_pkg::axi_resp_t bresp,
	input logic                bvalid,
	input logic                bready,
	input logic                push,
	input logic                full,
	input logic                empty,
	input logic                txd
);
	timeunit 1ns;
	timeprecision 100ps;

	int   fail_count = 0; // assertion failures so far
	logic in_flight;      // write captured, response not yet taken
	int   high_run;       // txd high cycles while bytes wait

	always_ff @(posedge clk) begin
		if (!rst) begin
			in_flight <= 1'b0;
		end else if (awvalid && awready && wvalid && wready) begin
			in_flight <= 1'b1;
		end else if (bvalid && bready) begin
			in_flight <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || !txd || empty) begin
			high_run <= 0;
		end else begin
			high_run <= high_run + 1;
		end
	end

	resp_held: assert property (@(posedge clk) disable iff (!rst)
		(bvalid && !bready) |=> (bvalid && $stable(bresp)))
		else begin
			fail_count++;
			$error("bvalid dropped or bresp changed before bready");
		end

	readies_low: assert property (@(posedge clk) disable iff (!rst)
		in_flight |-> (!awready && !wready))
		else begin
			fail_count++;
			$error("ready raised while a write is outstanding");
		end

	// never into a full fifo, and the byte has to land there
	no_push_full: assert property (@(posedge clk) disable iff (!rst)
		push |-> !full ##1 !empty)
		else begin
			fail_count++;
			$error("push into a full fifo or byte not stored");
		end

	// a full 0xff frame plus stop is the longest legal high stretch
	no_idle_gap: assert property (@(posedge clk) disable iff (!rst)
		high_run <= 9 * CLKS_PER_BIT + 2)
		else begin
			fail_count++;
			$error("txd idle while bytes are queued");
		end

	txd_after_reset: assert property (@(posedge clk) $rose(rst) |-> txd)
		else begin
			fail_count++;
			$error("txd not idle high after reset");
		end

endmodule

bind uart_axi_top uart_axi_checker #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_checker (
	.clk(clk), .rst(rst), .awvalid(awvalid), .awready(awready), .wvalid(wvalid),
	.wready(wready), .bresp(bresp), .bvalid(bvalid), .bready(bready), .push(push),
	.full(full), .empty(empty), .txd(txd)
);

/* testbench/uart_axi_tb.sv */
module uart_axi_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLKS_PER_BIT  = 8;
	localparam int HS_TIMEOUT    = 100;  // cycles for the readies to come back
	localparam int RESP_TIMEOUT  = 400;  // long enough for a full fifo to drain a frame
	localparam int DRAIN_TIMEOUT = 5000;

	logic                clk;
	logic                rst;
	uart_pkg::axi_addr_t awaddr;
	logic                awvalid;
	logic                awready;
	uart_pkg::axi_data_t wdata;
	uart_pkg::axi_strb_t wstrb;
	logic                wvalid;
	logic                wready;
	uart_pkg::axi_resp_t bresp;
	logic                bvalid;
	logic                bready;
	logic                txd;

	int                   seed = 32'h41df_66d0;
	uart_pkg::uart_byte_t expected_q[$]; // bytes from OKAY writes, oldest first

	uart_axi_top #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(4), .JITTER_SEED(16'hACE1)) DUT (
		.clk(clk), .rst(rst), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready), .txd(txd)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
			stop_run();
		end
	endtask

	task automatic next_drive_point();
		@(posedge clk);
		#10;
	endtask

	task automatic axi_write(input uart_pkg::axi_addr_t addr, input uart_pkg::axi_data_t data,
			input uart_pkg::axi_strb_t strb, input int bready_delay);
		uart_pkg::axi_resp_t exp_resp;
		int                  tries;
		if (addr[11:0] == uart_pkg::TXDATA_OFFSET && strb[0]) begin
			exp_resp = uart_pkg::RESP_OKAY;
			expected_q.push_back(data[7:0]);
		end else begin
			exp_resp = uart_pkg::RESP_SLVERR;
		end
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		tries   = 0;
		while (!(awready && wready)) begin // readies only move on edges
			next_drive_point();
			tries++;
			if (tries > HS_TIMEOUT) report_error("timeout: awready/wready never came back");
		end
		next_drive_point(); // joint aw/w transfer on this edge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		tries   = 0;
		while (!bvalid) begin
			next_drive_point();
			tries++;
			if (tries > RESP_TIMEOUT) report_error("timeout: no write response");
		end
		repeat (bready_delay) next_drive_point(); // response must stay pending
		check_value("bvalid", bvalid, 1'b1);
		check_value("bresp", bresp, exp_resp);
		bready = 1'b1;
		next_drive_point();
		bready = 1'b0;
	endtask

	task automatic drain_serial();
		int tries;
		tries = 0;
		while (expected_q.size() != 0) begin
			next_drive_point();
			tries++;
			if (tries > DRAIN_TIMEOUT) report_error("timeout: queued bytes never left on txd");
		end
	endtask

	// serial monitor, samples at mid-bit on falling edges
	task automatic receive_frame();
		uart_pkg::uart_byte_t rx;
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (txd !== 1'b0) report_error("start bit on txd ended early");
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			rx[i] = txd; // lsb first
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (txd !== 1'b1) report_error("framing error: stop bit on txd is low");
		if (expected_q.size() == 0) begin
			report_error("frame on txd with no byte queued");
		end else begin
			check_value("txd_byte", rx, expected_q.pop_front());
		end
	endtask

	always @(negedge clk) begin
		if (rst && txd === 1'b0) receive_frame();
	end

	always @(DUT.u_checker.fail_count) begin
		if (DUT.u_checker.fail_count != 0) report_error("bound protocol assertion failed");
	end

	initial begin
		int sel;
		rst = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		repeat (16) @(posedge clk);
		#10;
		rst = 1'b1;
		check_value("awready", awready, 1'b1);
		check_value("wready", wready, 1'b1);
		check_value("bvalid", bvalid, 1'b0);
		check_value("txd", txd, 1'b1);

		axi_write(32'h0000_0000, 32'h0000_00A5, 4'b0001, 0);
		drain_serial();

		// rejected writes, line must stay quiet
		axi_write(32'h0000_0004, 32'h0000_003C, 4'b0001, 0);
		axi_write(32'h0000_0000, 32'h0000_005A, 4'b1110, 1);
		for (int i = 0; i < 20 * CLKS_PER_BIT; i++) begin
			next_drive_point();
			check_value("txd", txd, 1'b1);
		end
		axi_write(32'h8000_0000, 32'h0000_00C3, 4'b0001, 0); // upper bits ignored

		repeat (10) axi_write(32'h0000_0000, $random(seed), 4'b1111, 0); // overruns the fifo
		drain_serial();

		axi_write(32'h0000_0000, 32'h0000_007E, 4'b0001, 6); // slow bready
		axi_write(32'h0000_0010, 32'h0000_0081, 4'b0001, 5);

		for (int n = 0; n < 30; n++) begin
			sel = {$random(seed)} % 8;
			repeat ({$random(seed)} % 16) next_drive_point();
			axi_write((sel == 6) ? 32'h0000_0010 : 32'h0000_0000, $random(seed),
				(sel == 7) ? 4'b0010 : 4'b1111, {$random(seed)} % 6);
		end
		drain_serial();
		repeat (2 * CLKS_PER_BIT) next_drive_point();

		if (DUT.u_checker.fail_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			report_error("bound protocol assertion failed");
		end
	end

endmodule
